/* source/harnessPkg.sv */
package harnessPkg;

	// Host command opcodes, anything else is rejected
	typedef enum logic [7:0] {
		CmdCreate = 8'h00,
		CmdUpdate = 8'h01,
		CmdRead   = 8'h02,
		CmdDelete = 8'h03,
		CmdRandom = 8'h10
	} opcode_t;

	// CRUD payload, address in the top word
	typedef struct packed {
		logic [31:0] addr;
		logic [31:0] data;
		logic [31:0] delay;
	} crudView_t;

	// Random traffic payload
	typedef struct packed {
		logic [31:0] seed;
		logic [31:0] accessCount;
		logic [31:0] baseOffset;
	} seedView_t;

	// Same 96 payload bits, read by whichever engine gets the command
	typedef union packed {
		crudView_t crud;
		seedView_t seed;
	} cmdPayload_u;

	// Opcode byte plus twelve payload bytes
	localparam int CmdBytes = 13;

	// Response word and its byte count on the return link
	localparam int RespWidth = 32;
	localparam int RespBytes = 4;
	localparam logic [RespWidth-1:0] RespBad = '1;

endpackage

/* source/memPkg.sv */
package memPkg;

	// ------------------------------------------------------------
	// Block store bus
	// ------------------------------------------------------------

	// Request address as seen by the engines and arbiter
	localparam int AddrWidth = 32;

	// Store word, also the read data bus
	localparam int DataWidth = 32;

	// ------------------------------------------------------------
	// Traffic generator
	// ------------------------------------------------------------

	// Fibonacci LFSR state, added to the base offset for each read
	localparam int LfsrWidth = 32;

endpackage

/* source/cmdReceiver.sv */
`timescale 1ns/1ps

module cmdReceiver (
	input  logic                    sys_clk_p,
	input  logic                    rstN,
	input  logic [7:0]              inByte,
	input  logic                    inValid,
	output logic                    inReady,
	output harnessPkg::opcode_t     crudOp,
	output harnessPkg::cmdPayload_u crudPayload,
	output logic                    crudValid,
	input  logic                    crudReady,
	output harnessPkg::cmdPayload_u randPayload,
	output logic                    randValid,
	input  logic                    randReady,
	output logic                    badValid,
	input  logic                    badReady
);
	import harnessPkg::*;

	localparam int CntWidth = $clog2(CmdBytes);
	localparam int WordWidth = CmdBytes * 8;

	logic [CntWidth-1:0]  byteCnt;
	logic [WordWidth-1:0] cmdWord;
	logic                 byteTake;
	logic                 lastByte;
	opcode_t              lastOp;

	// No new bytes while a routed command waits for its engine
	assign inReady = !(crudValid || randValid || badValid);
	assign byteTake = inValid && inReady;
	assign lastByte = (byteCnt == CntWidth'(CmdBytes - 1));

	// After twelve shifts the opcode byte sits just under the top byte
	assign lastOp = opcode_t'(cmdWord[(CmdBytes-1)*8-1 -: 8]);

	// Opcode in the top byte, payload below it
	assign crudOp = opcode_t'(cmdWord[WordWidth-1 -: 8]);
	assign crudPayload = cmdWord[WordWidth-9:0];
	assign randPayload = cmdWord[WordWidth-9:0];

	// Byte shifter, first byte ends up most significant
	always_ff @(posedge sys_clk_p) begin
		if (byteTake) begin
			cmdWord <= {cmdWord[WordWidth-9:0], inByte};
		end
	end

	// ------------------------------------------------------------
	// Byte count and routing
	// ------------------------------------------------------------
	always_ff @(posedge sys_clk_p) begin
		if (!rstN) begin
			byteCnt <= '0;
			crudValid <= 1'b0;
			randValid <= 1'b0;
			badValid <= 1'b0;
		end else begin
			if (byteTake) begin
				byteCnt <= lastByte ? '0 : byteCnt + 1'b1;
			end
			// Decode once on the final byte
			if (byteTake && lastByte) begin
				case (lastOp)
					CmdCreate, CmdRead, CmdUpdate, CmdDelete: crudValid <= 1'b1;
					CmdRandom: randValid <= 1'b1;
					default: badValid <= 1'b1;
				endcase
			end
			// Drop the valid once the chosen consumer takes it
			if (crudValid && crudReady) begin
				crudValid <= 1'b0;
			end
			if (randValid && randReady) begin
				randValid <= 1'b0;
			end
			if (badValid && badReady) begin
				badValid <= 1'b0;
			end
		end
	end

endmodule

/* source/crudEngine.sv */
`timescale 1ns/1ps

module crudEngine (
	input  logic                             sys_clk_p,
	input  logic                             rstN,
	input  harnessPkg::opcode_t              op,
	input  harnessPkg::cmdPayload_u          payload,
	input  logic                             cmdValid,
	output logic                             cmdReady,
	output logic                             req,
	output logic                             we,
	output logic [memPkg::AddrWidth-1:0]     addr,
	output logic [memPkg::DataWidth-1:0]     wdata,
	input  logic                             gnt,
	input  logic [memPkg::DataWidth-1:0]     rdata,
	input  logic                             rvalid,
	output logic [harnessPkg::RespWidth-1:0] resp,
	output logic                             respValid,
	input  logic                             respReady
);
	import harnessPkg::*;
	import memPkg::*;

	// FSM encoding
	localparam logic [2:0] StIdle   = 3'd0;
	localparam logic [2:0] StRdReq  = 3'd1;
	localparam logic [2:0] StRdWait = 3'd2;
	localparam logic [2:0] StWrReq  = 3'd3;
	localparam logic [2:0] StResp   = 3'd4;

	logic [2:0]           state;
	opcode_t              opReg;
	logic [AddrWidth-1:0] addrReg;
	logic [DataWidth-1:0] dataReg;

	assign cmdReady = (state == StIdle);
	assign req = (state == StRdReq) || (state == StWrReq);
	assign we = (state == StWrReq);
	assign addr = addrReg;
	assign respValid = (state == StResp);

	// ------------------------------------------------------------
	// Control
	// ------------------------------------------------------------
	always_ff @(posedge sys_clk_p) begin
		if (!rstN) begin
			state <= StIdle;
		end else begin
			case (state)
				StIdle: begin
					// Create skips the read, all others fetch the old word
					if (cmdValid) begin
						state <= (op == CmdCreate) ? StWrReq : StRdReq;
					end
				end
				StRdReq: begin
					if (gnt) begin
						state <= StRdWait;
					end
				end
				StRdWait: begin
					if (rvalid) begin
						state <= (opReg == CmdRead) ? StResp : StWrReq;
					end
				end
				StWrReq: begin
					if (gnt) begin
						state <= StResp;
					end
				end
				StResp: begin
					if (respReady) begin
						state <= StIdle;
					end
				end
				default: state <= StIdle;
			endcase
		end
	end

	// ------------------------------------------------------------
	// Command fields and result words
	// ------------------------------------------------------------
	always_ff @(posedge sys_clk_p) begin
		if (cmdReady && cmdValid) begin
			opReg <= op;
			addrReg <= payload.crud.addr;
			dataReg <= payload.crud.data;
			// Create writes the data and echoes it
			wdata <= payload.crud.data;
			resp <= payload.crud.data;
		end
		if ((state == StRdWait) && rvalid) begin
			case (opReg)
				CmdUpdate: begin
					// Sum wraps at 32 bits
					wdata <= rdata + dataReg;
					resp <= rdata + dataReg;
				end
				CmdDelete: begin
					wdata <= '0;
					resp <= rdata;
				end
				default: resp <= rdata;
			endcase
		end
	end

endmodule

/* source/trafficGen.sv */
`timescale 1ns/1ps

module trafficGen (
	input  logic                             sys_clk_p,
	input  logic                             rstN,
	input  harnessPkg::cmdPayload_u          payload,
	input  logic                             cmdValid,
	output logic                             cmdReady,
	output logic                             req,
	output logic                             we,
	output logic [memPkg::AddrWidth-1:0]     addr,
	output logic [memPkg::DataWidth-1:0]     wdata,
	input  logic                             gnt,
	input  logic [memPkg::DataWidth-1:0]     rdata,
	input  logic                             rvalid,
	output logic [harnessPkg::RespWidth-1:0] resp,
	output logic                             respValid,
	input  logic                             respReady
);
	import memPkg::*;

	// FSM encoding
	localparam logic [1:0] StIdle = 2'd0;
	localparam logic [1:0] StReq  = 2'd1;
	localparam logic [1:0] StWait = 2'd2;
	localparam logic [1:0] StResp = 2'd3;

	logic [1:0]           state;
	logic [LfsrWidth-1:0] lfsr;
	logic [LfsrWidth-1:0] seedInit;
	logic [31:0]          remaining;
	logic [AddrWidth-1:0] baseReg;
	logic [DataWidth-1:0] checksum;

	// One Fibonacci step, taps 31 21 1 0 fed back into bit 0
	function automatic logic [LfsrWidth-1:0] lfsrStep(input logic [LfsrWidth-1:0] cur);
		return {cur[LfsrWidth-2:0], cur[31] ^ cur[21] ^ cur[1] ^ cur[0]};
	endfunction

	// All-zero state would lock up the LFSR
	assign seedInit = (payload.seed.seed == '0) ? LfsrWidth'(1) : payload.seed.seed;

	// Reads only
	assign cmdReady = (state == StIdle);
	assign req = (state == StReq);
	assign we = 1'b0;
	assign wdata = '0;
	assign addr = baseReg + lfsr;
	assign resp = checksum;
	assign respValid = (state == StResp);

	// ------------------------------------------------------------
	// Control
	// ------------------------------------------------------------
	always_ff @(posedge sys_clk_p) begin
		if (!rstN) begin
			state <= StIdle;
		end else begin
			case (state)
				StIdle: begin
					// Zero count answers at once with a zero checksum
					if (cmdValid) begin
						state <= (payload.seed.accessCount == '0) ? StResp : StReq;
					end
				end
				StReq: begin
					if (gnt) begin
						state <= StWait;
					end
				end
				StWait: begin
					if (rvalid) begin
						state <= (remaining == 32'd1) ? StResp : StReq;
					end
				end
				default: begin
					if (respReady) begin
						state <= StIdle;
					end
				end
			endcase
		end
	end

	// ------------------------------------------------------------
	// LFSR, counter and checksum
	// ------------------------------------------------------------
	always_ff @(posedge sys_clk_p) begin
		if (cmdReady && cmdValid) begin
			// Step once ahead of the first access
			lfsr <= lfsrStep(seedInit);
			remaining <= payload.seed.accessCount;
			baseReg <= payload.seed.baseOffset;
			checksum <= '0;
		end
		if ((state == StWait) && rvalid) begin
			checksum <= checksum ^ rdata;
			remaining <= remaining - 32'd1;
			lfsr <= lfsrStep(lfsr);
		end
	end

endmodule

/* source/memArbiter.sv */
`timescale 1ns/1ps

module memArbiter (
	input  logic                         sys_clk_p,
	input  logic                         rstN,
	input  logic                         aReq,
	input  logic                         aWe,
	input  logic [memPkg::AddrWidth-1:0] aAddr,
	input  logic [memPkg::DataWidth-1:0] aWdata,
	output logic                         aGnt,
	output logic                         aRvalid,
	input  logic                         bReq,
	input  logic                         bWe,
	input  logic [memPkg::AddrWidth-1:0] bAddr,
	input  logic [memPkg::DataWidth-1:0] bWdata,
	output logic                         bGnt,
	output logic                         bRvalid,
	output logic                         en,
	output logic                         we,
	output logic [memPkg::AddrWidth-1:0] addr,
	output logic [memPkg::DataWidth-1:0] wdata
);

	// Set when port b took the last grant
	logic lastB;

	// Under contention the port that lost last time wins
	assign aGnt = aReq && (!bReq || lastB);
	assign bGnt = bReq && (!aReq || !lastB);

	// Winner onto the store port
	assign en = aGnt || bGnt;
	assign we = aGnt ? aWe : bWe;
	assign addr = aGnt ? aAddr : bAddr;
	assign wdata = aGnt ? aWdata : bWdata;

	// Read owner tracking, rvalid lines up with the store output
	always_ff @(posedge sys_clk_p) begin
		if (!rstN) begin
			lastB <= 1'b0;
			aRvalid <= 1'b0;
			bRvalid <= 1'b0;
		end else begin
			if (aGnt) begin
				lastB <= 1'b0;
			end else if (bGnt) begin
				lastB <= 1'b1;
			end
			aRvalid <= aGnt && !aWe;
			bRvalid <= bGnt && !bWe;
		end
	end

endmodule

/* source/blockStore.sv */
`timescale 1ns/1ps

module blockStore #(
	parameter int Depth = 256
) (
	input  logic                         sys_clk_p,
	input  logic                         en,
	input  logic                         we,
	input  logic [memPkg::AddrWidth-1:0] addr,
	input  logic [memPkg::DataWidth-1:0] wdata,
	output logic [memPkg::DataWidth-1:0] rdata
);
	import memPkg::*;

	// Only the low address bits index the array
	localparam int IdxWidth = $clog2(Depth);

	logic [DataWidth-1:0] mem [Depth];

	// Single port, write or registered read
	always_ff @(posedge sys_clk_p) begin
		if (en) begin
			if (we) begin
				mem[addr[IdxWidth-1:0]] <= wdata;
			end else begin
				rdata <= mem[addr[IdxWidth-1:0]];
			end
		end
	end

endmodule

/* source/respSender.sv */
`timescale 1ns/1ps

module respSender (
	input  logic                             sys_clk_p,
	input  logic                             rstN,
	input  logic [harnessPkg::RespWidth-1:0] crudResp,
	input  logic                             crudValid,
	output logic                             crudReady,
	input  logic [harnessPkg::RespWidth-1:0] randResp,
	input  logic                             randValid,
	output logic                             randReady,
	input  logic                             badValid,
	output logic                             badReady,
	output logic [7:0]                       outByte,
	output logic                             outValid,
	input  logic                             outReady
);
	import harnessPkg::*;

	localparam int CntWidth = $clog2(RespBytes);

	logic                 busy;
	logic [CntWidth-1:0]  byteCnt;
	logic [RespWidth-1:0] shiftReg;
	logic                 load;
	logic                 byteOut;

	// Fixed priority, CRUD then bad opcode then random
	assign crudReady = !busy;
	assign badReady = !busy && !crudValid;
	assign randReady = !busy && !crudValid && !badValid;
	assign load = !busy && (crudValid || badValid || randValid);

	// Most significant byte leaves first
	assign outValid = busy;
	assign outByte = shiftReg[RespWidth-1 -: 8];
	assign byteOut = outValid && outReady;

	always_ff @(posedge sys_clk_p) begin
		if (!rstN) begin
			busy <= 1'b0;
			byteCnt <= '0;
		end else if (load) begin
			busy <= 1'b1;
			byteCnt <= '0;
		end else if (byteOut) begin
			byteCnt <= byteCnt + 1'b1;
			// Free again after the last byte
			if (byteCnt == CntWidth'(RespBytes - 1)) begin
				busy <= 1'b0;
			end
		end
	end

	// Response shifter
	always_ff @(posedge sys_clk_p) begin
		if (load) begin
			if (crudValid) begin
				shiftReg <= crudResp;
			end else if (badValid) begin
				shiftReg <= RespBad;
			end else begin
				shiftReg <= randResp;
			end
		end else if (byteOut) begin
			shiftReg <= {shiftReg[RespWidth-9:0], 8'h00};
		end
	end

endmodule

/* source/oramHarnessTop.sv */
`timescale 1ns/1ps

module oramHarnessTop #(
	parameter int Depth = 256
) (
	input  logic       sys_clk_p,
	input  logic       rstN,
	input  logic [7:0] inByte,
	input  logic       inValid,
	output logic       inReady,
	output logic [7:0] outByte,
	output logic       outValid,
	input  logic       outReady
);
	import harnessPkg::*;
	import memPkg::*;

	// ------------------------------------------------------------
	// Command routing
	// ------------------------------------------------------------
	opcode_t     crudOp;
	cmdPayload_u crudPayload;
	cmdPayload_u randPayload;
	logic        crudCmdValid;
	logic        crudCmdReady;
	logic        randCmdValid;
	logic        randCmdReady;
	logic        badValid;
	logic        badReady;

	// Engine requests, port a is CRUD and port b is random traffic
	logic                 aReq;
	logic                 aWe;
	logic                 aGnt;
	logic                 aRvalid;
	logic [AddrWidth-1:0] aAddr;
	logic [DataWidth-1:0] aWdata;
	logic                 bReq;
	logic                 bWe;
	logic                 bGnt;
	logic                 bRvalid;
	logic [AddrWidth-1:0] bAddr;
	logic [DataWidth-1:0] bWdata;

	// Store port and shared read data
	logic                 memEn;
	logic                 memWe;
	logic [AddrWidth-1:0] memAddr;
	logic [DataWidth-1:0] memWdata;
	logic [DataWidth-1:0] memRdata;

	// Responses
	logic [RespWidth-1:0] crudResp;
	logic                 crudRespValid;
	logic                 crudRespReady;
	logic [RespWidth-1:0] randResp;
	logic                 randRespValid;
	logic                 randRespReady;

	cmdReceiver u_cmdReceiver (
		.sys_clk_p   (sys_clk_p),
		.rstN        (rstN),
		.inByte      (inByte),
		.inValid     (inValid),
		.inReady     (inReady),
		.crudOp      (crudOp),
		.crudPayload (crudPayload),
		.crudValid   (crudCmdValid),
		.crudReady   (crudCmdReady),
		.randPayload (randPayload),
		.randValid   (randCmdValid),
		.randReady   (randCmdReady),
		.badValid    (badValid),
		.badReady    (badReady)
	);

	// ------------------------------------------------------------
	// Engines
	// ------------------------------------------------------------
	crudEngine u_crudEngine (
		.sys_clk_p (sys_clk_p),
		.rstN      (rstN),
		.op        (crudOp),
		.payload   (crudPayload),
		.cmdValid  (crudCmdValid),
		.cmdReady  (crudCmdReady),
		.req       (aReq),
		.we        (aWe),
		.addr      (aAddr),
		.wdata     (aWdata),
		.gnt       (aGnt),
		.rdata     (memRdata),
		.rvalid    (aRvalid),
		.resp      (crudResp),
		.respValid (crudRespValid),
		.respReady (crudRespReady)
	);

	trafficGen u_trafficGen (
		.sys_clk_p (sys_clk_p),
		.rstN      (rstN),
		.payload   (randPayload),
		.cmdValid  (randCmdValid),
		.cmdReady  (randCmdReady),
		.req       (bReq),
		.we        (bWe),
		.addr      (bAddr),
		.wdata     (bWdata),
		.gnt       (bGnt),
		.rdata     (memRdata),
		.rvalid    (bRvalid),
		.resp      (randResp),
		.respValid (randRespValid),
		.respReady (randRespReady)
	);

	// ------------------------------------------------------------
	// Shared store
	// ------------------------------------------------------------
	memArbiter u_memArbiter (
		.sys_clk_p (sys_clk_p),
		.rstN      (rstN),
		.aReq      (aReq),
		.aWe       (aWe),
		.aAddr     (aAddr),
		.aWdata    (aWdata),
		.aGnt      (aGnt),
		.aRvalid   (aRvalid),
		.bReq      (bReq),
		.bWe       (bWe),
		.bAddr     (bAddr),
		.bWdata    (bWdata),
		.bGnt      (bGnt),
		.bRvalid   (bRvalid),
		.en        (memEn),
		.we        (memWe),
		.addr      (memAddr),
		.wdata     (memWdata)
	);

	blockStore #(
		.Depth (Depth)
	) u_blockStore (
		.sys_clk_p (sys_clk_p),
		.en        (memEn),
		.we        (memWe),
		.addr      (memAddr),
		.wdata     (memWdata),
		.rdata     (memRdata)
	);

	// Bytes back to the host
	respSender u_respSender (
		.sys_clk_p (sys_clk_p),
		.rstN      (rstN),
		.crudResp  (crudResp),
		.crudValid (crudRespValid),
		.crudReady (crudRespReady),
		.randResp  (randResp),
		.randValid (randRespValid),
		.randReady (randRespReady),
		.badValid  (badValid),
		.badReady  (badReady),
		.outByte   (outByte),
		.outValid  (outValid),
		.outReady  (outReady)
	);

endmodule

/* testbench/oramHarnessTb.sv */
`timescale 1ns/1ps

module oramHarnessTb;
	import harnessPkg::*;

	localparam int WordBits = CmdBytes * 8;
	localparam int WaitLimit = 5000;

	logic       sys_clk_p;
	logic       rstN;
	logic [7:0] inByte;
	logic       inValid;
	logic       inReady;
	logic [7:0] outByte;
	logic       outValid;
	logic       outReady;

	// Reference copy of the store by low address byte
	logic [31:0] refMem [256];
	logic [31:0] stimLfsr;
	bit          backPressure;

	oramHarnessTop #(
		.Depth (256)
	) u_oramHarnessTop (
		.sys_clk_p (sys_clk_p),
		.rstN      (rstN),
		.inByte    (inByte),
		.inValid   (inValid),
		.inReady   (inReady),
		.outByte   (outByte),
		.outValid  (outValid),
		.outReady  (outReady)
	);

	always #50 sys_clk_p = ~sys_clk_p;

	// ------------------------------------------------------------
	// LFSR, stimulus bits and reference model
	// ------------------------------------------------------------

	// Shift left with bits 31 21 1 0 fed back into bit 0
	function automatic logic [31:0] lfsrNext(input logic [31:0] cur);
		return {cur[30:0], cur[31] ^ cur[21] ^ cur[1] ^ cur[0]};
	endfunction

	// One step per bit taken
	function automatic logic [31:0] randBits(input int n);
		logic [31:0] val;
		val = '0;
		for (int i = 0; i < n; i++) begin
			stimLfsr = lfsrNext(stimLfsr);
			val = {val[30:0], stimLfsr[0]};
		end
		return val;
	endfunction

	// Expected CRUD response and the matching model update
	function automatic logic [31:0] modelCrud(input opcode_t op, input logic [31:0] a,
			input logic [31:0] d);
		logic [31:0] old;
		old = refMem[a[7:0]];
		case (op)
			CmdCreate: begin
				refMem[a[7:0]] = d;
				return d;
			end
			CmdUpdate: begin
				refMem[a[7:0]] = old + d;
				return old + d;
			end
			CmdDelete: begin
				refMem[a[7:0]] = '0;
				return old;
			end
			default: return old;
		endcase
	endfunction

	// XOR over count reads with the LFSR stepped before each one
	function automatic logic [31:0] modelChecksum(input logic [31:0] seed,
			input logic [31:0] count, input logic [31:0] offset);
		logic [31:0] state;
		logic [31:0] sum;
		logic [31:0] rdAddr;
		state = (seed == '0) ? 32'd1 : seed;
		sum = '0;
		for (int i = 0; i < count; i++) begin
			state = lfsrNext(state);
			rdAddr = offset + state;
			sum = sum ^ refMem[rdAddr[7:0]];
		end
		return sum;
	endfunction

	// ------------------------------------------------------------
	// Checks
	// ------------------------------------------------------------
	task automatic stopWithFailure(input string why);
		$display("%s", why);
		$display("SOME TESTS FAILED");
		$fatal(1);
	endtask

	task automatic compareResp(input string name, input logic [RespWidth-1:0] got,
			input logic [RespWidth-1:0] exp);
		if (got !== exp) begin
			stopWithFailure($sformatf("[FAIL] %s got %h expected %h", name, got, exp));
		end
	endtask

	task automatic compareByte(input string name, input logic [7:0] got,
			input logic [7:0] exp);
		if (got !== exp) begin
			stopWithFailure($sformatf("[FAIL] %s got %h expected %h", name, got, exp));
		end
	endtask

	// ------------------------------------------------------------
	// Byte drivers called 1 ns after a rising edge
	// ------------------------------------------------------------
	task automatic sendByte(input logic [7:0] value);
		int waitCnt;
		inByte = value;
		inValid = 1'b1;
		waitCnt = 0;
		@(posedge sys_clk_p);
		while (!inReady) begin
			waitCnt++;
			if (waitCnt > WaitLimit) begin
				stopWithFailure("Command byte was never accepted");
			end
			@(posedge sys_clk_p);
		end
		#1;
		inValid = 1'b0;
	endtask

	// Opcode first and then payload MSB first
	task automatic sendCmd(input logic [7:0] op, input cmdPayload_u payload);
		logic [WordBits-1:0] word;
		word = {op, payload};
		for (int i = 0; i < CmdBytes; i++) begin
			sendByte(word[WordBits-1-8*i -: 8]);
		end
	endtask

	task automatic recvByte(output logic [7:0] value);
		int waitCnt;
		int stall;
		// Random stretch of outReady low before taking the byte
		if (backPressure) begin
			stall = randBits(3);
			outReady = 1'b0;
			repeat (stall) begin
				@(posedge sys_clk_p);
				#1;
			end
		end
		outReady = 1'b1;
		waitCnt = 0;
		@(posedge sys_clk_p);
		while (!outValid) begin
			waitCnt++;
			if (waitCnt > WaitLimit) begin
				stopWithFailure("Response byte never arrived");
			end
			@(posedge sys_clk_p);
		end
		value = outByte;
		#1;
		outReady = 1'b0;
	endtask

	task automatic recvResp(output logic [31:0] word);
		logic [7:0] b;
		word = '0;
		for (int i = 0; i < 4; i++) begin
			recvByte(b);
			word = {word[23:0], b};
		end
	endtask

	// Nothing more may come out once a response is complete
	task automatic checkQuiet;
		repeat (3) begin
			@(posedge sys_clk_p);
			if (outValid) begin
				stopWithFailure("Extra response byte after a complete response");
			end
			#1;
		end
	endtask

	// ------------------------------------------------------------
	// Command helpers
	// ------------------------------------------------------------
	function automatic cmdPayload_u crudPayload(input logic [31:0] a, input logic [31:0] d);
		cmdPayload_u p;
		p.crud.addr = a;
		p.crud.data = d;
		// Random bits in the reserved delay field
		p.crud.delay = randBits(32);
		return p;
	endfunction

	task automatic runCrud(input opcode_t op, input logic [31:0] a, input logic [31:0] d);
		logic [31:0] exp;
		logic [31:0] got;
		exp = modelCrud(op, a, d);
		sendCmd(op, crudPayload(a, d));
		recvResp(got);
		compareResp("crud resp", got, exp);
	endtask

	task automatic runRandom(input logic [31:0] seed, input logic [31:0] count,
			input logic [31:0] offset);
		cmdPayload_u p;
		logic [31:0] got;
		p.seed.seed = seed;
		p.seed.accessCount = count;
		p.seed.baseOffset = offset;
		sendCmd(CmdRandom, p);
		recvResp(got);
		compareResp("checksum resp", got, modelChecksum(seed, count, offset));
	endtask

	function automatic opcode_t pickCrudOp;
		logic [31:0] sel;
		sel = randBits(2);
		case (sel[1:0])
			2'd0: return CmdCreate;
			2'd1: return CmdRead;
			2'd2: return CmdUpdate;
			default: return CmdDelete;
		endcase
	endfunction

	// ------------------------------------------------------------
	// Directed tests
	// ------------------------------------------------------------

	// Fills every word with random upper address bits
	task automatic createThenRead;
		logic [31:0] upper;
		for (int a = 0; a < 256; a++) begin
			upper = randBits(24);
			runCrud(CmdCreate, {upper[23:0], 8'(a)}, randBits(32));
		end
		repeat (20) begin
			runCrud(CmdRead, randBits(32), randBits(32));
		end
	endtask

	task automatic updateThenDelete;
		logic [31:0] a;
		repeat (10) begin
			runCrud(CmdUpdate, randBits(32), randBits(32));
		end
		repeat (5) begin
			a = randBits(32);
			runCrud(CmdDelete, a, randBits(32));
			// Model now holds zero here
			runCrud(CmdRead, a, randBits(32));
		end
	endtask

	task automatic randomChecksums;
		runRandom(randBits(32), 20, randBits(32));
		runRandom(32'h0, 10, randBits(32));
		runRandom(randBits(32), 0, randBits(32));
	endtask

	task automatic badOpcodeRecovery;
		logic [31:0] got;
		sendCmd(8'h55, crudPayload(randBits(32), randBits(32)));
		recvResp(got);
		compareResp("bad opcode resp", got, 32'hffff_ffff);
		runCrud(CmdRead, randBits(32), randBits(32));
	endtask

	// Checked byte by byte so loss or duplication shows up
	task automatic byteBackPressure;
		opcode_t op;
		logic [31:0] a;
		logic [31:0] d;
		logic [31:0] exp;
		logic [7:0]  b;
		backPressure = 1'b1;
		repeat (12) begin
			op = pickCrudOp();
			a = randBits(32);
			d = randBits(32);
			exp = modelCrud(op, a, d);
			sendCmd(op, crudPayload(a, d));
			for (int i = 0; i < 4; i++) begin
				recvByte(b);
				compareByte("outByte", b, exp[31-8*i -: 8]);
			end
			checkQuiet();
		end
		backPressure = 1'b0;
	endtask

	// CRUD reads stay in order while the checksum may land anywhere
	task automatic engineOverlap;
		cmdPayload_u randP;
		logic [31:0] readAddr [3];
		logic [31:0] crudExp [3];
		logic [31:0] sumExp;
		logic [31:0] word;
		logic [31:0] got [$];
		int          crudIdx;
		bit          sumSeen;
		randP.seed.seed = randBits(32);
		randP.seed.accessCount = 64;
		randP.seed.baseOffset = randBits(32);
		sumExp = modelChecksum(randP.seed.seed, 64, randP.seed.baseOffset);
		for (int i = 0; i < 3; i++) begin
			readAddr[i] = randBits(32);
			crudExp[i] = modelCrud(CmdRead, readAddr[i], '0);
		end
		fork
			begin
				sendCmd(CmdRandom, randP);
				for (int i = 0; i < 3; i++) begin
					sendCmd(CmdRead, crudPayload(readAddr[i], randBits(32)));
				end
			end
			begin
				for (int i = 0; i < 4; i++) begin
					recvResp(word);
					got.push_back(word);
				end
			end
		join
		crudIdx = 0;
		sumSeen = 1'b0;
		foreach (got[i]) begin
			if (crudIdx < 3 && got[i] === crudExp[crudIdx]) begin
				crudIdx++;
			end else if (!sumSeen && got[i] === sumExp) begin
				sumSeen = 1'b1;
			end else begin
				compareResp("overlap resp", got[i], (crudIdx < 3) ? crudExp[crudIdx] : sumExp);
			end
		end
	endtask

	// ------------------------------------------------------------
	// Sequence
	// ------------------------------------------------------------
	initial begin
		sys_clk_p = 1'b0;
		rstN = 1'b0;
		inByte = '0;
		inValid = 1'b0;
		outReady = 1'b0;
		backPressure = 1'b0;
		stimLfsr = 32'h8c1c;
		repeat (2) @(posedge sys_clk_p);
		#1;
		rstN = 1'b1;
		@(posedge sys_clk_p);
		if (!inReady || outValid) begin
			stopWithFailure("Handshake outputs not idle after reset");
		end
		#1;
		createThenRead();
		updateThenDelete();
		randomChecksums();
		badOpcodeRecovery();
		byteBackPressure();
		engineOverlap();
		$display("ALL TESTS PASSED");
		$finish;
	end

endmodule

/* project.f */
source/harnessPkg.sv
source/memPkg.sv
source/cmdReceiver.sv
source/crudEngine.sv
source/trafficGen.sv
source/memArbiter.sv
source/blockStore.sv
source/respSender.sv
source/oramHarnessTop.sv
testbench/oramHarnessTb.sv

/* Bender.yml */
package:
  name: oram_harness

sources:
  - source/harnessPkg.sv
  - source/memPkg.sv
  - source/cmdReceiver.sv
  - source/crudEngine.sv
  - source/trafficGen.sv
  - source/memArbiter.sv
  - source/blockStore.sv
  - source/respSender.sv
  - source/oramHarnessTop.sv
  - target: simulation
    files:
      - testbench/oramHarnessTb.sv
